// ==== wormhole_pkg.sv ====
`default_nettype none

// Widths and vector types seen on the wormhole link side of the port.
// Everything here describes the network, not the protocol riding on it.
package wormhole_pkg;

  // Number of physical data wires on one link
  localparam int flit_width_c = 32;

  // Destination coordinate, packed as {y,x} in the low bits of the first flit
  localparam int cord_width_c = 8;

  // Length field that sits just above the coordinate in the first flit
  // It counts the flits that follow the first flit of a packet
  localparam int len_width_c = 8;

  // One flit as it travels over the link
  typedef logic [flit_width_c-1:0] flit_t;

  // Destination coordinate of a packet
  typedef logic [cord_width_c-1:0] cord_t;

  // Flit count within a packet
  typedef logic [len_width_c-1:0] len_t;

endpackage : wormhole_pkg

`default_nettype wire

// ==== proto_pkg.sv ====
`default_nettype none

// Widths and types of the higher level protocol that feeds the port
package proto_pkg;

  // Protocol header bits carried above the wormhole coordinate and length
  localparam int pr_hdr_width_c = 48;

  // Full header as handed to the port
  // It is the wormhole coordinate and length followed by the protocol header
  localparam int hdr_width_c = wormhole_pkg::cord_width_c
                             + wormhole_pkg::len_width_c
                             + pr_hdr_width_c;

  // One protocol data word
  localparam int pr_data_width_c = 64;

  // Header word as accepted on the header port
  typedef logic [hdr_width_c-1:0] hdr_t;

  // Data word as accepted on the data port
  typedef logic [pr_data_width_c-1:0] pr_data_t;

  // Which serializer currently owns the link
  typedef enum logic
  {
    e_hdr  = 1'b0,
    e_data = 1'b1
  } stream_state_e;

endpackage : proto_pkg

`default_nettype wire

// ==== flit_piso.sv ====
`timescale 1ns/10ps
`default_nettype none

// Parallel-in, serial-out register for one wide word
// The word is loaded in a single transfer and then handed out one flit per yumi,
// starting with the least significant flit
module flit_piso
  import wormhole_pkg::*;
#(
  parameter int width_p = flit_width_c,
  parameter int els_p   = 2
)
(
  input  wire logic                     clk_i,
  input  wire logic                     rst_i,

  // Wide side, a ready/valid transfer loads the whole word
  input  wire logic [width_p*els_p-1:0] data_i,
  input  wire logic                     valid_i,
  output      logic                     ready_o,

  // Narrow side, the consumer takes a flit by raising yumi while valid is high
  output      flit_t                    data_o,
  output      logic                     valid_o,
  input  wire logic                     yumi_i
);

  // A single flit still needs one index bit so the counter has a legal width
  localparam int idx_width_lp = (els_p > 1) ? $clog2(els_p) : 1;

  // Index of the final flit of a word
  localparam logic [idx_width_lp-1:0] last_idx_lp = idx_width_lp'(els_p - 1);

  // Stored word, only meaningful while full_r is set
  logic [width_p*els_p-1:0] word_r;

  // Flit currently presented on data_o
  logic [idx_width_lp-1:0] idx_r;

  // Set from the load until the last flit is taken
  logic full_r;

  logic load;

  // The register only takes a new word once it has fully drained
  assign ready_o = ~full_r;
  assign load    = valid_i & ready_o;

  assign valid_o = full_r;
  assign data_o  = word_r[idx_r*width_p +: width_p];

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      full_r <= 1'b0;
      idx_r  <= '0;
    end
    else if (load)
    begin
      // Flit 0 shows up in the cycle after the load
      full_r <= 1'b1;
      idx_r  <= '0;
    end
    else if (yumi_i)
    begin
      if (idx_r == last_idx_lp)
      begin
        // Emptying here leaves one idle cycle before ready_o can load again
        full_r <= 1'b0;
        idx_r  <= '0;
      end
      else
      begin
        idx_r <= idx_r + 1'b1;
      end
    end
  end

  // The word itself carries no control meaning
  always_ff @(posedge clk_i)
  begin
    if (load)
    begin
      word_r <= data_i;
    end
  end

  // A flit that is offered but not taken has to stay put for the consumer
  a_hold_flit : assert property (
    @(posedge clk_i) disable iff (rst_i)
    (valid_o && !yumi_i) |=> $stable(data_o)
  );

  // The consumer may only take a flit that is actually offered
  a_yumi_valid : assert property (
    @(posedge clk_i) disable iff (rst_i)
    yumi_i |-> valid_o
  );

endmodule : flit_piso

`default_nettype wire

// ==== flit_counter.sv ====
`timescale 1ns/10ps
`default_nettype none

// Tracks the position of the link inside the current packet
// The length is read straight from the first flit and kept for the rest of the packet
module flit_counter
  import wormhole_pkg::*;
#(
  parameter int hdr_len_p = 2
)
(
  input  wire logic clk_i,
  input  wire logic rst_i,

  // One pulse per flit that crosses the link
  input  wire logic accept_i,

  // Length field of the flit now on the link, only used on the first flit
  input  wire len_t len_i,

  output      logic hdr_last_o,
  output      logic pkt_last_o
);

  // Index of the final header flit
  localparam len_t hdr_last_idx_lp = len_t'(hdr_len_p - 1);

  // Position of the next flit within the packet, zero for the first flit
  len_t idx_r;

  // Length captured from the first flit
  len_t len_r;

  // Length in force for the flit at idx_r
  len_t cur_len;

  // The first flit still sits on the link, so its own length field applies
  assign cur_len = (idx_r == '0) ? len_i : len_r;

  assign hdr_last_o = (idx_r == hdr_last_idx_lp);
  assign pkt_last_o = (idx_r == cur_len);

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      idx_r <= '0;
    end
    else if (accept_i)
    begin
      // Wrap back to the first flit when the packet is done
      idx_r <= pkt_last_o ? '0 : idx_r + 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept_i && (idx_r == '0))
    begin
      len_r <= len_i;
    end
  end

  // A length that ends the packet inside the header would cut the header short
  a_len_covers_hdr : assert property (
    @(posedge clk_i) disable iff (rst_i)
    (accept_i && (idx_r == '0)) |-> (len_i >= hdr_last_idx_lp)
  );

endmodule : flit_counter

`default_nettype wire

// ==== stream_fsm.sv ====
`timescale 1ns/10ps
`default_nettype none

// Chooses which serializer owns the link
// The header phase lasts for the header flits and the data phase for the rest
module stream_fsm
  import proto_pkg::*;
(
  input  wire logic clk_i,
  input  wire logic rst_i,

  // One pulse per flit that crosses the link
  input  wire logic accept_i,

  // Position flags for the flit now on the link
  input  wire logic hdr_last_i,
  input  wire logic pkt_last_i,

  output      logic is_hdr_o,
  output      logic is_data_o
);

  stream_state_e state_r;
  stream_state_e state_n;

  always_comb
  begin
    state_n = state_r;
    case (state_r)
      e_hdr:
      begin
        // A header-only packet ends on its last header flit and stays here
        if (accept_i && hdr_last_i && !pkt_last_i)
        begin
          state_n = e_data;
        end
      end
      e_data:
      begin
        // The next packet always starts with its header
        if (accept_i && pkt_last_i)
        begin
          state_n = e_hdr;
        end
      end
      default:
      begin
        state_n = e_hdr;
      end
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      state_r <= e_hdr;
    end
    else
    begin
      state_r <= state_n;
    end
  end

  assign is_hdr_o  = (state_r == e_hdr);
  assign is_data_o = (state_r == e_data);

  // Both serializers must never share the link
  a_one_owner : assert property (
    @(posedge clk_i) disable iff (rst_i)
    !(is_hdr_o && is_data_o)
  );

endmodule : stream_fsm

`default_nettype wire

// ==== wormhole_stream_in.sv ====
`timescale 1ns/10ps
`default_nettype none

// Injection side of a wormhole network port
// A wide header and then wide data words are streamed onto the narrower link
// one flit at a time, without collecting the packet first
// Only one packet is on the link at a time
// The next header may be loaded early but waits until the current packet ends
module wormhole_stream_in
  import wormhole_pkg::*;
  import proto_pkg::*;
(
  input  wire logic     clk_i,
  input  wire logic     rst_i,

  // Wormhole and protocol header
  input  wire hdr_t     hdr_i,
  input  wire logic     hdr_v_i,
  output      logic     hdr_ready_and_o,

  // Protocol data words
  input  wire pr_data_t data_i,
  input  wire logic     data_v_i,
  output      logic     data_ready_and_o,

  // Link into the network
  output      flit_t    link_data_o,
  output      logic     link_v_o,
  input  wire logic     link_ready_and_i
);

  // Flits per header and per data word
  // Both widths are whole multiples of the flit width
  localparam int hdr_els_lp  = hdr_width_c / flit_width_c;
  localparam int data_els_lp = pr_data_width_c / flit_width_c;

  // Current phase from the FSM
  logic is_hdr;
  logic is_data;

  // Position flags from the counter
  logic hdr_last;
  logic pkt_last;

  // A flit crosses the link in this cycle
  logic link_accept;

  // Header serializer outputs and its take signal
  flit_t hdr_flit;
  logic  hdr_flit_v;
  logic  hdr_yumi;

  // Data serializer outputs and its take signal
  flit_t data_flit;
  logic  data_flit_v;
  logic  data_yumi;

  assign link_accept = link_v_o & link_ready_and_i;

  // Only the serializer that owns the link sees the transfer
  assign hdr_yumi  = is_hdr & link_accept;
  assign data_yumi = is_data & link_accept;

  // The header is loaded whole and sent low flit first
  flit_piso #(
    .width_p (flit_width_c),
    .els_p   (hdr_els_lp)
  ) u_hdr_piso (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .data_i  (hdr_i),
    .valid_i (hdr_v_i),
    .ready_o (hdr_ready_and_o),
    .data_o  (hdr_flit),
    .valid_o (hdr_flit_v),
    .yumi_i  (hdr_yumi)
  );

  // Each data word goes out the same way as the header
  flit_piso #(
    .width_p (flit_width_c),
    .els_p   (data_els_lp)
  ) u_data_piso (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .data_i  (data_i),
    .valid_i (data_v_i),
    .ready_o (data_ready_and_o),
    .data_o  (data_flit),
    .valid_o (data_flit_v),
    .yumi_i  (data_yumi)
  );

  // The length field sits right above the coordinate in the first header flit
  flit_counter #(
    .hdr_len_p  (hdr_els_lp)
  ) u_counter (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .accept_i   (link_accept),
    .len_i      (hdr_flit[cord_width_c +: len_width_c]),
    .hdr_last_o (hdr_last),
    .pkt_last_o (pkt_last)
  );

  stream_fsm u_fsm (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .accept_i   (link_accept),
    .hdr_last_i (hdr_last),
    .pkt_last_i (pkt_last),
    .is_hdr_o   (is_hdr),
    .is_data_o  (is_data)
  );

  // Link mux follows the phase
  assign link_data_o = is_hdr ? hdr_flit   : data_flit;
  assign link_v_o    = is_hdr ? hdr_flit_v : data_flit_v;

endmodule : wormhole_stream_in

`default_nettype wire

// ==== tb_wormhole_stream_in.sv ====
`timescale 1ns/10ps
`default_nettype none

// Testbench for the wormhole injection port
// Packets come from a fixed table, and every flit that crosses the link is
// compared in order with a queue built from the same table
module tb_wormhole_stream_in
  import wormhole_pkg::*;
  import proto_pkg::*;
();

  localparam int num_pkts_c    = 8;
  localparam int max_words_c   = 4;
  localparam int wait_limit_c  = 200;
  localparam int drain_limit_c = 2000;
  localparam logic [31:0] lfsr_seed_c = 32'h8ad5_1681;
  // Feedback mask for x^32 + x^22 + x^2 + x + 1
  localparam logic [31:0] lfsr_taps_c = 32'h8020_0003;

  logic     clk_i;
  logic     rst_i;
  hdr_t     hdr_i;
  logic     hdr_v_i;
  logic     hdr_ready_and_o;
  pr_data_t data_i;
  logic     data_v_i;
  logic     data_ready_and_o;
  flit_t    link_data_o;
  logic     link_v_o;
  logic     link_ready_and_i;

  // Packet table, one row per packet
  cord_t                     tbl_cord   [num_pkts_c];
  int                        tbl_words  [num_pkts_c];
  logic [pr_hdr_width_c-1:0] tbl_pr_hdr [num_pkts_c];
  pr_data_t                  tbl_data   [num_pkts_c][max_words_c];

  // Expected link flits in order, with a label and packet number for each one
  flit_t exp_q[$];
  string name_q[$];
  int    pkt_q[$];

  // The input driver and the link side each step their own LFSR state
  logic [31:0] gap_lfsr_r;
  logic [31:0] link_lfsr_r;

  // Flit offered under back-pressure in the previous cycle
  logic  held_v;
  flit_t held_data;
  logic  monitor_on;

  int value_errors;
  int hold_errors;
  int stream_errors;
  int timeout_errors;

  wormhole_stream_in u_dut (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .hdr_i            (hdr_i),
    .hdr_v_i          (hdr_v_i),
    .hdr_ready_and_o  (hdr_ready_and_o),
    .data_i           (data_i),
    .data_v_i         (data_v_i),
    .data_ready_and_o (data_ready_and_o),
    .link_data_o      (link_data_o),
    .link_v_o         (link_v_o),
    .link_ready_and_i (link_ready_and_i)
  );

  always #4 clk_i = ~clk_i;

  // One Galois step on the given state, returning the bit shifted out
  function automatic logic lfsr_bit(inout logic [31:0] state);
    logic lsb;
    lsb   = state[0];
    state = state >> 1;
    if (lsb)
    begin
      state = state ^ lfsr_taps_c;
    end
    return lsb;
  endfunction

  function automatic int take_bits(inout logic [31:0] state, input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++)
    begin
      v = (v << 1) | int'(lfsr_bit(state));
    end
    return v;
  endfunction

  // Data pattern depends on both the packet and the word position
  function automatic pr_data_t data_pattern(input int p, input int w);
    return {8'(p), 8'(w), 16'hc0de, 8'(~p), 8'(~w), 16'h5a3c};
  endfunction

  // Length field counts the flits after the first one
  function automatic len_t pkt_len(input int p);
    return len_t'(tbl_words[p] * 2 + 1);
  endfunction

  function automatic hdr_t make_header(input int p);
    return {tbl_pr_hdr[p], pkt_len(p), tbl_cord[p]};
  endfunction

  task automatic set_entry(input int p, input cord_t cord, input int words,
                           input logic [pr_hdr_width_c-1:0] pr_hdr);
    tbl_cord[p]   = cord;
    tbl_words[p]  = words;
    tbl_pr_hdr[p] = pr_hdr;
    for (int w = 0; w < max_words_c; w++)
    begin
      tbl_data[p][w] = data_pattern(p, w);
    end
  endtask

  task automatic load_table();
    // Two header-only rows in a row, and one more between long packets
    set_entry(0, 8'h12, 2, 48'h0a0b_0c0d_0e0f);
    set_entry(1, 8'h34, 0, 48'h1357_9bdf_2468);
    set_entry(2, 8'h56, 0, 48'hfedc_ba98_7654);
    set_entry(3, 8'h78, 4, 48'h0123_4567_89ab);
    set_entry(4, 8'h9a, 1, 48'hdead_beef_0001);
    set_entry(5, 8'hbc, 3, 48'h5555_aaaa_3c3c);
    set_entry(6, 8'hde, 0, 48'h8000_0000_0001);
    set_entry(7, 8'hf0, 4, 48'h7e57_0f0f_c3c3);
  endtask

  // Header low flit first, then each data word low flit first
  task automatic build_expected();
    hdr_t hdr;
    for (int p = 0; p < num_pkts_c; p++)
    begin
      hdr = make_header(p);
      exp_q.push_back(hdr[flit_width_c-1:0]);
      name_q.push_back("hdr_lo");
      pkt_q.push_back(p);
      exp_q.push_back(hdr[2*flit_width_c-1:flit_width_c]);
      name_q.push_back("hdr_hi");
      pkt_q.push_back(p);
      for (int w = 0; w < tbl_words[p]; w++)
      begin
        exp_q.push_back(tbl_data[p][w][flit_width_c-1:0]);
        name_q.push_back("data_lo");
        pkt_q.push_back(p);
        exp_q.push_back(tbl_data[p][w][2*flit_width_c-1:flit_width_c]);
        name_q.push_back("data_hi");
        pkt_q.push_back(p);
      end
    end
  endtask

  // Idle port shows no link flit and accepts on both input ports
  task automatic check_idle(input string label);
    logic [2:0] seen;
    seen = {link_v_o, hdr_ready_and_o, data_ready_and_o};
    assert (seen == 3'b011)
    else
    begin
      value_errors++;
      $display("** Error [%s] expected %b, actual %b", label, 3'b011, seen);
    end
  endtask

  // Offers one word on the header or data port after an optional gap
  // Called on a falling edge and returns on a falling edge after the transfer
  task automatic offer_word(input bit to_hdr, input pr_data_t word);
    int gap;
    int waited;
    gap = take_bits(gap_lfsr_r, 1) ? take_bits(gap_lfsr_r, 2) : 0;
    repeat (gap) @(negedge clk_i);
    if (to_hdr)
    begin
      hdr_i   = hdr_t'(word);
      hdr_v_i = 1'b1;
    end
    else
    begin
      data_i   = word;
      data_v_i = 1'b1;
    end
    // Ready only moves on a rising edge, so it is safe to look at it here
    waited = 0;
    while (!(to_hdr ? hdr_ready_and_o : data_ready_and_o) && (waited < wait_limit_c))
    begin
      @(negedge clk_i);
      waited++;
    end
    assert (waited < wait_limit_c)
    else
    begin
      timeout_errors++;
      $display("Timeout: the %s port never became ready", to_hdr ? "header" : "data");
    end
    // The transfer happens on the rising edge in between
    @(negedge clk_i);
    hdr_v_i  = 1'b0;
    data_v_i = 1'b0;
  endtask

  // Link side: random back-pressure and the flit scoreboard
  // Flit and valid only change on a rising edge, so they are stable here
  always @(negedge clk_i)
  begin
    if (monitor_on)
    begin
      link_ready_and_i = (take_bits(link_lfsr_r, 2) != 0);
      if (held_v)
      begin
        assert (link_v_o && (link_data_o === held_data))
        else
        begin
          hold_errors++;
          $display("** Error [link_hold] expected %h, actual %h", held_data, link_data_o);
        end
      end
      held_v    = link_v_o && !link_ready_and_i;
      held_data = link_data_o;
      if (link_v_o && link_ready_and_i)
      begin
        assert (exp_q.size() != 0)
        else
        begin
          stream_errors++;
          $display("Extra flit %h was sent after every expected flit", link_data_o);
        end
        if (exp_q.size() != 0)
        begin
          assert (link_data_o === exp_q[0])
          else
          begin
            value_errors++;
            $display("** Error [%s pkt %0d] expected %h, actual %h",
                     name_q[0], pkt_q[0], exp_q[0], link_data_o);
          end
          void'(exp_q.pop_front());
          void'(name_q.pop_front());
          void'(pkt_q.pop_front());
        end
      end
    end
  end

  initial
  begin
    int waited;
    clk_i            = 1'b0;
    rst_i            = 1'b1;
    hdr_i            = '0;
    hdr_v_i          = 1'b0;
    data_i           = '0;
    data_v_i         = 1'b0;
    link_ready_and_i = 1'b1;
    gap_lfsr_r       = lfsr_seed_c;
    link_lfsr_r      = lfsr_seed_c;
    held_v           = 1'b0;
    held_data        = '0;
    monitor_on       = 1'b0;
    value_errors     = 0;
    hold_errors      = 0;
    stream_errors    = 0;
    timeout_errors   = 0;
    load_table();
    build_expected();

    // Four rising edges see the reset
    repeat (4)
    begin
      @(negedge clk_i);
      check_idle("reset_idle");
    end
    rst_i = 1'b0;
    @(negedge clk_i);
    check_idle("after_reset");
    monitor_on = 1'b1;

    // Next header goes in while the previous data may still be draining
    for (int p = 0; p < num_pkts_c; p++)
    begin
      offer_word(1'b1, pr_data_t'(make_header(p)));
      for (int w = 0; w < tbl_words[p]; w++)
      begin
        offer_word(1'b0, tbl_data[p][w]);
      end
    end

    waited = 0;
    while ((exp_q.size() != 0) && (waited < drain_limit_c))
    begin
      @(negedge clk_i);
      waited++;
    end
    assert (exp_q.size() == 0)
    else
    begin
      timeout_errors++;
      $display("Timeout: %0d link flits never appeared", exp_q.size());
    end
    // Last flit crosses on the next rising edge and the link goes quiet
    @(negedge clk_i);
    check_idle("end_idle");

    $display("Errors: %0d value, %0d hold, %0d stream, %0d timeout",
             value_errors, hold_errors, stream_errors, timeout_errors);
    if ((value_errors + hold_errors + stream_errors + timeout_errors) == 0)
    begin
      $display("Simulation passed");
    end
    else
    begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule : tb_wormhole_stream_in

`default_nettype wire

// ==== all.f ====
wormhole_pkg.sv
proto_pkg.sv
flit_piso.sv
flit_counter.sv
stream_fsm.sv
wormhole_stream_in.sv
tb_wormhole_stream_in.sv

// ==== Makefile ====
# Verilator build and run for the wormhole injection port

VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_wormhole_stream_in
FILELIST  = all.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = Simulation passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

# The log decides the result, the run itself may exit with any status
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
	  echo "Result: PASS"; \
	else \
	  echo "Result: FAIL"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
